/* source/soc_periph_config.svh */
/*
 * SoC peripheral subsystem configuration
 * Bus widths, peripheral address map and cluster geometry
 */

`ifndef SOC_PERIPH_CONFIG_SVH
`define SOC_PERIPH_CONFIG_SVH

// Bus widths, strobe width is DW/8
`define SOC_PERIPH_AW 32
`define SOC_PERIPH_DW 32

// Peripheral region and its windows
`define SOC_PERIPH_BASE_ADDR 32'h1A10_0000
`define SOC_CTRL_OFFSET 'h4000
`define STDOUT_OFFSET 'hF000
`define SOC_PERIPH_WINDOW 'h1000

// Platform geometry
`define SOC_N_CORES 8
`define SOC_N_CLUSTERS 1

// APB slaves behind the bridge
`define SOC_N_APB_SLAVES 2

`endif

/* source/soc_periph_pkg.sv */
/*
 * SoC peripheral subsystem types
 * AXI-Lite channel bundles, APB request/response, address map rules
 * and the stdout character event
 */

`include "soc_periph_config.svh"

package soc_periph_pkg;

  // Bus response code, only the two used here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Master side of all five AXI-Lite channels
  typedef struct packed {
    logic                         aw_valid;
    logic [`SOC_PERIPH_AW-1:0]    aw_addr;
    logic                         w_valid;
    logic [`SOC_PERIPH_DW-1:0]    w_data;
    logic [`SOC_PERIPH_DW/8-1:0]  w_strb;
    logic                         b_ready;
    logic                         ar_valid;
    logic [`SOC_PERIPH_AW-1:0]    ar_addr;
    logic                         r_ready;
  } axi_lite_req_t;

  // Slave side
  typedef struct packed {
    logic                         aw_ready;
    logic                         w_ready;
    logic                         b_valid;
    resp_e                        b_resp;
    logic                         ar_ready;
    logic                         r_valid;
    logic [`SOC_PERIPH_DW-1:0]    r_data;
    resp_e                        r_resp;
  } axi_lite_rsp_t;

  // APB request shared by all slaves, select travels separately
  typedef struct packed {
    logic [`SOC_PERIPH_AW-1:0]    paddr;
    logic                         pwrite;
    logic [`SOC_PERIPH_DW-1:0]    pwdata;
    logic [`SOC_PERIPH_DW/8-1:0]  pstrb;
    logic                         penable;
  } apb_req_t;

  typedef struct packed {
    logic [`SOC_PERIPH_DW-1:0]    prdata;
    logic                         pready;
    logic                         pslverr;
  } apb_rsp_t;

  // Inclusive address range mapped to slave idx
  typedef struct packed {
    logic [31:0]                  idx;
    logic [`SOC_PERIPH_AW-1:0]    start_addr;
    logic [`SOC_PERIPH_AW-1:0]    end_addr;
  } addr_rule_t;

  // One character written by one core
  typedef struct packed {
    logic                         valid;
    logic [$clog2(`SOC_N_CORES)-1:0] core_idx;
    logic [5:0]                   cluster_idx;  // offset bits 11:6
    logic [7:0]                   char_data;
  } stdout_evt_t;

endpackage

/* source/apb_addr_decode.sv */
/*
 * APB address decoder
 * Matches an address against a table of inclusive ranges and returns
 * a one-hot slave select, or a miss when nothing matches
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module apb_addr_decode #(
  parameter int unsigned NoRules = 2,
  parameter type         rule_t  = soc_periph_pkg::addr_rule_t
) (
  input  logic [`SOC_PERIPH_AW-1:0] addr_i,
  input  rule_t [NoRules-1:0]       rules_i,
  output logic [NoRules-1:0]        sel_o,
  output logic                      miss_o
);

  logic matched;

  always_comb begin
    sel_o   = '0;
    matched = 1'b0;
    // First hit in table order wins
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (!matched &&
          (addr_i >= rules_i[i].start_addr) &&
          (addr_i <= rules_i[i].end_addr)) begin
        sel_o[rules_i[i].idx] = 1'b1;
        matched               = 1'b1;
      end
    end
  end

  assign miss_o = ~matched;

endmodule

/* source/axi_lite_to_apb.sv */
/*
 * AXI-Lite to APB bridge
 * Accepts one AXI-Lite read or write at a time, runs a single APB
 * transfer to the decoded slave and returns the response.
 * Reads win over writes, address misses answer SLVERR without APB.
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module axi_lite_to_apb (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  soc_periph_pkg::axi_lite_req_t                       axi_req_i,
  output soc_periph_pkg::axi_lite_rsp_t                       axi_rsp_o,
  input  soc_periph_pkg::addr_rule_t [`SOC_N_APB_SLAVES-1:0]  addr_map_i,
  output soc_periph_pkg::apb_req_t                            apb_req_o,
  output logic [`SOC_N_APB_SLAVES-1:0]                        psel_o,
  input  soc_periph_pkg::apb_rsp_t [`SOC_N_APB_SLAVES-1:0]    apb_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    RESP
  } state_e;

  state_e                          state_q, state_d;
  logic                            rd_acc, wr_acc;
  logic [`SOC_PERIPH_AW-1:0]       addr_q, addr_d;
  logic [`SOC_PERIPH_DW-1:0]       wdata_q, wdata_d;
  logic [`SOC_PERIPH_DW/8-1:0]     strb_q, strb_d;
  logic                            write_q, write_d;
  logic [`SOC_N_APB_SLAVES-1:0]    sel_q, sel_d;
  logic [`SOC_N_APB_SLAVES-1:0]    dec_sel;
  logic                            dec_miss;
  logic [`SOC_PERIPH_DW-1:0]       rdata_q, rdata_d;
  soc_periph_pkg::resp_e           resp_q, resp_d;
  soc_periph_pkg::apb_rsp_t        act_rsp;

  // Accept only in IDLE, read has priority
  assign rd_acc = (state_q == IDLE) & axi_req_i.ar_valid;
  assign wr_acc = (state_q == IDLE) & ~axi_req_i.ar_valid &
                  axi_req_i.aw_valid & axi_req_i.w_valid;

  // Next value of the address register, decoded at accept time
  assign addr_d = rd_acc ? axi_req_i.ar_addr :
                  wr_acc ? axi_req_i.aw_addr : addr_q;

  apb_addr_decode #(
    .NoRules (`SOC_N_APB_SLAVES),
    .rule_t  (soc_periph_pkg::addr_rule_t)
  ) i_apb_addr_decode (
    .addr_i  (addr_d),
    .rules_i (addr_map_i),
    .sel_o   (dec_sel),
    .miss_o  (dec_miss)
  );

  // Response of whichever slave is selected
  always_comb begin
    act_rsp = '0;
    for (int unsigned i = 0; i < `SOC_N_APB_SLAVES; i++) begin
      if (sel_q[i]) begin
        act_rsp = apb_rsp_i[i];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    wdata_d = wdata_q;
    strb_d  = strb_q;
    write_d = write_q;
    sel_d   = sel_q;
    rdata_d = rdata_q;
    resp_d  = resp_q;
    unique case (state_q)
      IDLE: begin
        if (rd_acc || wr_acc) begin
          write_d = wr_acc;
          wdata_d = axi_req_i.w_data;
          strb_d  = wr_acc ? axi_req_i.w_strb : '0;
          sel_d   = dec_sel;
          if (dec_miss) begin
            // No slave behind this address, answer right away
            rdata_d = '0;
            resp_d  = soc_periph_pkg::RESP_SLVERR;
            state_d = RESP;
          end else begin
            state_d = SETUP;
          end
        end
      end
      SETUP: begin
        state_d = ACCESS;
      end
      ACCESS: begin
        if (act_rsp.pready) begin
          rdata_d = write_q ? '0 : act_rsp.prdata;
          resp_d  = act_rsp.pslverr ? soc_periph_pkg::RESP_SLVERR
                                    : soc_periph_pkg::RESP_OKAY;
          state_d = RESP;
        end
      end
      RESP: begin
        // Hold until the master takes the response
        if (write_q ? axi_req_i.b_ready : axi_req_i.r_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    wdata_q <= wdata_d;
    strb_q  <= strb_d;
    write_q <= write_d;
    sel_q   <= sel_d;
    rdata_q <= rdata_d;
    resp_q  <= resp_d;
  end

  // AXI-Lite side
  assign axi_rsp_o.ar_ready = rd_acc;
  assign axi_rsp_o.aw_ready = wr_acc;
  assign axi_rsp_o.w_ready  = wr_acc;
  assign axi_rsp_o.b_valid  = (state_q == RESP) & write_q;
  assign axi_rsp_o.b_resp   = resp_q;
  assign axi_rsp_o.r_valid  = (state_q == RESP) & ~write_q;
  assign axi_rsp_o.r_data   = rdata_q;
  assign axi_rsp_o.r_resp   = resp_q;

  // APB side
  assign apb_req_o.paddr   = addr_q;
  assign apb_req_o.pwrite  = write_q;
  assign apb_req_o.pwdata  = wdata_q;
  assign apb_req_o.pstrb   = strb_q;
  assign apb_req_o.penable = (state_q == ACCESS);
  assign psel_o = ((state_q == SETUP) || (state_q == ACCESS)) ? sel_q : '0;

endmodule

/* source/soc_ctrl_regs.sv */
/*
 * SoC control register block
 * Read-only platform info, two byte-writable scratch registers and
 * the end-of-computation register driving eoc and the exit code
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module soc_ctrl_regs (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  input  logic                     psel_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output logic                     eoc_o,
  output logic [30:0]              exit_code_o
);

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_WINDOW);

  localparam logic [OffW-1:0] OffInfo     = OffW'('h0);
  localparam logic [OffW-1:0] OffScratch0 = OffW'('h4);
  localparam logic [OffW-1:0] OffScratch1 = OffW'('h8);
  localparam logic [OffW-1:0] OffEoc      = OffW'('hC);

  // Clusters in the upper half, cores in the lower half
  localparam logic [31:0] InfoWord = {16'(`SOC_N_CLUSTERS), 16'(`SOC_N_CORES)};

  logic [OffW-1:0]           offset;
  logic                      access;
  logic [`SOC_PERIPH_DW-1:0] scratch_q [2];
  logic                      eoc_q;
  logic [30:0]               exit_code_q;
  logic [`SOC_PERIPH_DW-1:0] rdata;
  logic                      err;

  assign offset = apb_req_i.paddr[OffW-1:0];
  assign access = psel_i & apb_req_i.penable;

  // Read mux and error decode
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    unique case (offset)
      OffInfo: begin
        rdata = InfoWord;
        err   = apb_req_i.pwrite;
      end
      OffScratch0: rdata = scratch_q[0];
      OffScratch1: rdata = scratch_q[1];
      OffEoc:      rdata = {eoc_q, exit_code_q};
      default:     err   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q[0] <= '0;
      scratch_q[1] <= '0;
      eoc_q        <= 1'b0;
      exit_code_q  <= '0;
    end else if (access && apb_req_i.pwrite) begin
      for (int unsigned b = 0; b < `SOC_PERIPH_DW/8; b++) begin
        if (apb_req_i.pstrb[b]) begin
          if (offset == OffScratch0) begin
            scratch_q[0][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
          end
          if (offset == OffScratch1) begin
            scratch_q[1][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
          end
        end
      end
      if (offset == OffEoc) begin
        eoc_q       <= 1'b1;
        exit_code_q <= apb_req_i.pwdata[30:0];
      end
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = err;

  assign eoc_o       = eoc_q;
  assign exit_code_o = exit_code_q;

endmodule

/* source/apb_stdout.sv */
/*
 * APB stdout port
 * Each byte write becomes one character event tagged with the core and
 * cluster index taken from the write address
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module apb_stdout (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  soc_periph_pkg::apb_req_t    apb_req_i,
  input  logic                        psel_i,
  output soc_periph_pkg::apb_rsp_t    apb_rsp_o,
  output soc_periph_pkg::stdout_evt_t stdout_o
);

  localparam int unsigned CoreW = $clog2(`SOC_N_CORES);

  logic             wr_access;
  logic             has_byte;
  logic [7:0]       char_d;
  logic             valid_q;
  logic [CoreW-1:0] core_q;
  logic [5:0]       cluster_q;
  logic [7:0]       char_q;

  assign wr_access = psel_i & apb_req_i.penable & apb_req_i.pwrite;

  // Lowest strobed byte is the character
  always_comb begin
    char_d   = '0;
    has_byte = 1'b0;
    for (int b = `SOC_PERIPH_DW/8 - 1; b >= 0; b--) begin
      if (apb_req_i.pstrb[b]) begin
        char_d   = apb_req_i.pwdata[8*b +: 8];
        has_byte = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wr_access & has_byte;
    end
  end

  // Core in offset bits 5:3, cluster in 11:6
  always_ff @(posedge clk_i) begin
    if (wr_access && has_byte) begin
      core_q    <= apb_req_i.paddr[3 +: CoreW];
      cluster_q <= apb_req_i.paddr[11:6];
      char_q    <= char_d;
    end
  end

  assign stdout_o.valid       = valid_q;
  assign stdout_o.core_idx    = core_q;
  assign stdout_o.cluster_idx = cluster_q;
  assign stdout_o.char_data   = char_q;

  // Write-only port, reads see zero
  assign apb_rsp_o.prdata  = '0;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = 1'b0;

endmodule

/* source/soc_peripherals.sv */
/*
 * SoC peripheral subsystem
 * AXI-Lite slave port bridged to APB, with the SoC control registers
 * and the stdout port as the two APB slaves
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module soc_peripherals (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  soc_periph_pkg::axi_lite_req_t axi_req_i,
  output soc_periph_pkg::axi_lite_rsp_t axi_rsp_o,
  output logic                          eoc_o,
  output logic [30:0]                   exit_code_o,
  output soc_periph_pkg::stdout_evt_t   stdout_o
);

  localparam logic [`SOC_PERIPH_AW-1:0] SocCtrlStart =
    `SOC_PERIPH_BASE_ADDR + `SOC_CTRL_OFFSET;
  localparam logic [`SOC_PERIPH_AW-1:0] StdoutStart =
    `SOC_PERIPH_BASE_ADDR + `STDOUT_OFFSET;

  soc_periph_pkg::addr_rule_t [`SOC_N_APB_SLAVES-1:0] addr_map;
  soc_periph_pkg::apb_req_t                           apb_req;
  logic [`SOC_N_APB_SLAVES-1:0]                       psel;
  soc_periph_pkg::apb_rsp_t [`SOC_N_APB_SLAVES-1:0]   apb_rsp;

  // Slave 0 is the control block, slave 1 the stdout port
  assign addr_map[0] = '{idx: 32'd0, start_addr: SocCtrlStart,
                         end_addr: SocCtrlStart + `SOC_PERIPH_WINDOW - 1};
  assign addr_map[1] = '{idx: 32'd1, start_addr: StdoutStart,
                         end_addr: StdoutStart + `SOC_PERIPH_WINDOW - 1};

  axi_lite_to_apb i_axi_lite_to_apb (
    .clk_i,
    .arst_n_i,
    .axi_req_i,
    .axi_rsp_o,
    .addr_map_i (addr_map),
    .apb_req_o  (apb_req ),
    .psel_o     (psel    ),
    .apb_rsp_i  (apb_rsp )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i,
    .arst_n_i,
    .apb_req_i  (apb_req   ),
    .psel_i     (psel[0]   ),
    .apb_rsp_o  (apb_rsp[0]),
    .eoc_o,
    .exit_code_o
  );

  apb_stdout i_stdout (
    .clk_i,
    .arst_n_i,
    .apb_req_i  (apb_req   ),
    .psel_i     (psel[1]   ),
    .apb_rsp_o  (apb_rsp[1]),
    .stdout_o
  );

endmodule

/* sim/tb_soc_peripherals.sv */
/*
 * Testbench for the SoC peripheral subsystem
 * Drives AXI-Lite reads and writes, predicts responses and stdout
 * events from a register model and compares them in a monitor
 */

`timescale 1ns/1ps

`include "soc_periph_config.svh"

module tb_soc_peripherals;

  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 16;
  // Info 3, scratch 80, EOC 2, stdout 13, error cases 16, back-pressure 5
  localparam int unsigned NumTrans    = 119;
  localparam logic [31:0] CtrlBase    = `SOC_PERIPH_BASE_ADDR + `SOC_CTRL_OFFSET;
  localparam logic [31:0] StdoutBase  = `SOC_PERIPH_BASE_ADDR + `STDOUT_OFFSET;
  localparam logic [31:0] InfoWord    = (`SOC_N_CLUSTERS << 16) | `SOC_N_CORES;

  typedef struct packed {
    logic                  is_write;
    logic [31:0]           data;
    soc_periph_pkg::resp_e resp;
  } exp_rsp_t;

  logic                          clk;
  logic                          arst_n;
  soc_periph_pkg::axi_lite_req_t axi_req;
  soc_periph_pkg::axi_lite_rsp_t axi_rsp;
  logic                          eoc;
  logic [30:0]                   exit_code;
  soc_periph_pkg::stdout_evt_t   stdout_evt;

  soc_periph_pkg::addr_rule_t    addr_map [2];
  logic [31:0]                   scratch [2];
  logic                          model_eoc;
  logic [30:0]                   model_code;
  exp_rsp_t                      exp_rsp_q [$];
  soc_periph_pkg::stdout_evt_t   exp_evt_q [$];
  integer                        seed;
  int                            errors;
  int                            rsp_issued;
  int                            rsp_done;
  int                            stall_cycles;

  soc_peripherals soc_peripherals_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .axi_req_i   (axi_req),
    .axi_rsp_o   (axi_rsp),
    .eoc_o       (eoc),
    .exit_code_o (exit_code),
    .stdout_o    (stdout_evt)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Index of the first window holding addr or -1 on a miss
  function automatic int find_slave(input logic [31:0] addr);
    int slave;
    slave = -1;
    for (int i = 0; i < 2; i++) begin
      if (slave < 0 && addr >= addr_map[i].start_addr && addr <= addr_map[i].end_addr) begin
        slave = addr_map[i].idx;
      end
    end
    return slave;
  endfunction

  // Expected response from the model state before the access
  function automatic exp_rsp_t predict_rsp(input logic is_write, input logic [31:0] addr);
    exp_rsp_t    r;
    int          slave;
    logic [31:0] off;
    r     = '{is_write: is_write, data: 32'h0, resp: soc_periph_pkg::RESP_SLVERR};
    slave = find_slave(addr);
    off   = addr - ((slave == 1) ? StdoutBase : CtrlBase);
    if (slave == 1) begin
      r.resp = soc_periph_pkg::RESP_OKAY;
    end else if (slave == 0) begin
      if (off == 32'h0 && !is_write) begin
        r.resp = soc_periph_pkg::RESP_OKAY;
        r.data = InfoWord;
      end else if (off == 32'h4 || off == 32'h8) begin
        r.resp = soc_periph_pkg::RESP_OKAY;
        r.data = is_write ? 32'h0 : scratch[off == 32'h8];
      end else if (off == 32'hC) begin
        r.resp = soc_periph_pkg::RESP_OKAY;
        r.data = is_write ? 32'h0 : {model_eoc, model_code};
      end
    end
    return r;
  endfunction

  // Updates the model for a write and queues any stdout event
  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int                          slave;
    logic [31:0]                 off;
    logic                        found;
    soc_periph_pkg::stdout_evt_t evt;
    slave = find_slave(addr);
    off   = addr - ((slave == 1) ? StdoutBase : CtrlBase);
    found = 1'b0;
    evt   = '0;
    if (slave == 0 && (off == 32'h4 || off == 32'h8)) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) scratch[off == 32'h8][8*b +: 8] = data[8*b +: 8];
      end
    end else if (slave == 0 && off == 32'hC) begin
      model_eoc  = 1'b1;
      model_code = data[30:0];
    end else if (slave == 1 && strb != 4'h0) begin
      evt.valid       = 1'b1;
      evt.core_idx    = off[5:3];
      evt.cluster_idx = off[11:6];
      for (int b = 0; b < 4; b++) begin
        if (strb[b] && !found) begin
          evt.char_data = data[8*b +: 8];
          found         = 1'b1;
        end
      end
      exp_evt_q.push_back(evt);
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    exp_rsp_q.push_back(predict_rsp(1'b1, addr));
    apply_write(addr, data, strb);
    rsp_issued++;
    @(negedge clk);
    axi_req.aw_valid = 1'b1;
    axi_req.aw_addr  = addr;
    axi_req.w_valid  = 1'b1;
    axi_req.w_data   = data;
    axi_req.w_strb   = strb;
    #1;
    while (!axi_rsp.aw_ready) begin
      @(negedge clk);
      #1;
    end
    check_value(axi_rsp.w_ready, 1'b1, "w_ready with aw_ready");
    @(negedge clk);
    axi_req.aw_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr);
    exp_rsp_q.push_back(predict_rsp(1'b0, addr));
    rsp_issued++;
    @(negedge clk);
    axi_req.ar_valid = 1'b1;
    axi_req.ar_addr  = addr;
    #1;
    while (!axi_rsp.ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    axi_req.ar_valid = 1'b0;
  endtask

  // Read and write presented in the same cycle with the read going first
  task automatic read_and_write(input logic [31:0] raddr, input logic [31:0] waddr,
                                input logic [31:0] data);
    exp_rsp_q.push_back(predict_rsp(1'b0, raddr));
    exp_rsp_q.push_back(predict_rsp(1'b1, waddr));
    apply_write(waddr, data, 4'hF);
    rsp_issued += 2;
    @(negedge clk);
    axi_req.ar_valid = 1'b1;
    axi_req.ar_addr  = raddr;
    axi_req.aw_valid = 1'b1;
    axi_req.aw_addr  = waddr;
    axi_req.w_valid  = 1'b1;
    axi_req.w_data   = data;
    axi_req.w_strb   = 4'hF;
    #1;
    while (!axi_rsp.ar_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    axi_req.ar_valid = 1'b0;
    #1;
    while (!axi_rsp.aw_ready) begin
      @(negedge clk);
      #1;
    end
    check_value(axi_rsp.w_ready, 1'b1, "w_ready with aw_ready");
    @(negedge clk);
    axi_req.aw_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
  endtask

  task automatic wait_idle();
    wait (rsp_done == rsp_issued);
    @(negedge clk);
  endtask

  // Response and stdout monitor that also drives r_ready and b_ready
  initial begin : monitor
    exp_rsp_t                    exp;
    exp_rsp_t                    held;
    soc_periph_pkg::stdout_evt_t exp_evt;
    logic                        holding;
    int                          wait_left;
    holding   = 1'b0;
    wait_left = 0;
    held      = '0;
    forever begin
      @(negedge clk);
      if (stdout_evt.valid) begin
        if (exp_evt_q.size() == 0) begin
          $display("Unexpected stdout event at %0t ns", $time);
          errors++;
        end else begin
          exp_evt = exp_evt_q.pop_front();
          check_value(stdout_evt.core_idx, exp_evt.core_idx, "stdout core index");
          check_value(stdout_evt.cluster_idx, exp_evt.cluster_idx, "stdout cluster index");
          check_value(stdout_evt.char_data, exp_evt.char_data, "stdout character");
        end
      end
      if (axi_rsp.r_valid || axi_rsp.b_valid) begin
        if (!holding) begin
          holding       = 1'b1;
          held.is_write = axi_rsp.b_valid;
          held.data     = axi_rsp.r_data;
          held.resp     = axi_rsp.b_valid ? axi_rsp.b_resp : axi_rsp.r_resp;
          wait_left     = stall_cycles;
          stall_cycles  = 0;
        end else begin
          check_value(axi_rsp.b_valid, held.is_write, "held response channel");
          check_value(axi_rsp.r_data, held.data, "held read data");
          check_value(held.is_write ? axi_rsp.b_resp : axi_rsp.r_resp, held.resp,
                      "held response code");
        end
        check_value(axi_rsp.ar_ready | axi_rsp.aw_ready | axi_rsp.w_ready, 1'b0,
                    "accept while responding");
        if (wait_left > 0) begin
          wait_left--;
          axi_req.r_ready = 1'b0;
          axi_req.b_ready = 1'b0;
        end else begin
          axi_req.r_ready = 1'b1;
          axi_req.b_ready = 1'b1;
          if (exp_rsp_q.size() == 0) begin
            $display("Response at %0t ns with no transaction outstanding", $time);
            errors++;
          end else begin
            exp = exp_rsp_q.pop_front();
            check_value(held.is_write, exp.is_write, "response order (1 = write)");
            if (!exp.is_write) check_value(held.data, exp.data, "read data");
            check_value(held.resp, exp.resp, "response code");
          end
          rsp_done++;
          holding = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    #((NumTrans * 20 + ResetCycles) * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles, errors so far %0d",
             NumTrans * 20 + ResetCycles, errors);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] code;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] addr;
    seed         = 32'he6c5_be4d;
    errors       = 0;
    rsp_issued   = 0;
    rsp_done     = 0;
    stall_cycles = 0;
    scratch[0]   = 32'h0;
    scratch[1]   = 32'h0;
    model_eoc    = 1'b0;
    model_code   = 31'h0;
    axi_req      = '0;
    axi_req.r_ready = 1'b1;
    axi_req.b_ready = 1'b1;
    arst_n       = 1'b0;
    addr_map[0]  = '{idx: 0, start_addr: CtrlBase,
                     end_addr: CtrlBase + `SOC_PERIPH_WINDOW - 1};
    addr_map[1]  = '{idx: 1, start_addr: StdoutBase,
                     end_addr: StdoutBase + `SOC_PERIPH_WINDOW - 1};
    repeat (ResetCycles) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value(eoc, 1'b0, "eoc after reset");
    check_value(exit_code, 31'h0, "exit code after reset");
    check_value(stdout_evt.valid, 1'b0, "stdout valid after reset");

    // Read-only platform info
    read_reg(CtrlBase);
    write_reg(CtrlBase, $random(seed), 4'hF);
    read_reg(CtrlBase);

    // Scratch registers with byte strobes
    repeat (40) begin
      addr = CtrlBase + (($random(seed) & 1) ? 32'h8 : 32'h4);
      data = $random(seed);
      strb = $random(seed);
      write_reg(addr, data, strb);
      read_reg(addr);
    end

    // End of computation
    code = $random(seed);
    write_reg(CtrlBase + 32'hC, code, 4'hF);
    wait_idle();
    check_value(eoc, 1'b1, "eoc after EOC write");
    check_value(exit_code, code[30:0], "exit code");
    read_reg(CtrlBase + 32'hC);

    // Stdout characters from random cores and one write with no strobe
    repeat (12) begin
      addr = StdoutBase + ((($random(seed) & 7) << 3));
      write_reg(addr, $random(seed), $random(seed));
    end
    write_reg(StdoutBase + 32'h18, 32'h4142_4344, 4'h0);

    // Misses and unused control offsets
    for (int i = 0; i < 7; i++) begin
      case (i)
        0: addr = 32'h0;
        1: addr = `SOC_PERIPH_BASE_ADDR + 32'h3004;
        2: addr = CtrlBase + 32'h1004;
        3: addr = CtrlBase + 32'h10;
        4: addr = CtrlBase + 32'h2;
        5: addr = CtrlBase + 32'hFFC;
        default: addr = StdoutBase - 32'h4;
      endcase
      write_reg(addr, $random(seed), 4'hF);
      read_reg(addr);
    end
    read_reg(CtrlBase + 32'h4);
    read_reg(CtrlBase + 32'h8);

    // Back-pressure on both response channels followed by read priority
    wait_idle();
    stall_cycles = 1 + ($random(seed) & 7);
    read_reg(CtrlBase + 32'h4);
    write_reg(CtrlBase + 32'h8, $random(seed), 4'hF);
    wait_idle();
    stall_cycles = 1 + ($random(seed) & 7);
    write_reg(CtrlBase + 32'h4, $random(seed), 4'h5);
    wait_idle();
    read_and_write(CtrlBase + 32'h4, CtrlBase + 32'h4, $random(seed));

    wait_idle();
    repeat (4) @(negedge clk);
    if (exp_evt_q.size() != 0) begin
      $display("Missing %0d expected stdout events", exp_evt_q.size());
      errors++;
    end
    $display("Transactions: %0d, errors: %0d", rsp_done, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/soc_periph_pkg.sv
source/apb_addr_decode.sv
source/axi_lite_to_apb.sv
source/soc_ctrl_regs.sv
source/apb_stdout.sv
source/soc_peripherals.sv
sim/tb_soc_peripherals.sv

/* Bender.yml */
package:
  name: soc_peripherals

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/soc_periph_pkg.sv
      - source/apb_addr_decode.sv
      - source/axi_lite_to_apb.sv
      - source/soc_ctrl_regs.sv
      - source/apb_stdout.sv
      - source/soc_peripherals.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_soc_peripherals.sv
